// File: tdc_link.f
rtl/tdc_link_pkg.sv
rtl/event_arbiter.sv
rtl/record_fifo.sv
rtl/uart_record_tx.sv
rtl/tdc_link_top.sv
sim/tdc_link_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the TDC link testbench with Verilator.
# The exit status is the simulator's; a failing run ends in $fatal.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir

verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    -f tdc_link.f \
    --top-module tdc_link_tb \
    -o tdc_link_sim

./obj_dir/tdc_link_sim

// File: sim/tdc_link_tb.sv
`timescale 1ns/1ps

module tdc_link_tb;

    localparam int NUM_CH        = 6;
    localparam int FIFO_BITS     = 4;
    localparam int CLKS_PER_BIT  = 8;
    localparam int BIT_NS        = CLKS_PER_BIT * 20;
    localparam int MID_NS        = CLKS_PER_BIT * 10 + 10;   // Lands on a falling clock edge
    localparam int BURST_LEN     = 40;
    localparam int TOTAL_RECORDS = NUM_CH + NUM_CH + 3 * NUM_CH + BURST_LEN;
    localparam int WATCHDOG_NS   = TOTAL_RECORDS * 60 * CLKS_PER_BIT * 20 + 50000;
    localparam int KIND_TDC      = 0;
    localparam int KIND_LINE     = 1;
    localparam int KIND_FRAME    = 2;

    logic                     clk            = 1'b0;
    logic                     rst            = 1'b1;
    logic [NUM_CH-1:0]        tdc_valid      = '0;
    logic [NUM_CH-1:0][31:0]  tdc_data       = '0;
    logic [NUM_CH-1:0]        line_mark      = '0;
    logic [NUM_CH-1:0]        frame_mark     = '0;
    logic [NUM_CH-1:0]        frame_reversed = '0;
    logic [NUM_CH-1:0]        tdc_ack;
    logic [NUM_CH-1:0]        line_ack;
    logic [NUM_CH-1:0]        frame_ack;
    logic                     tx;
    logic                     tx_busy;

    // Pending source events, oldest first
    int          ev_ch[$];
    int          ev_kind[$];
    logic [31:0] ev_data[$];
    logic [47:0] expected_q[$];
    string       test_name = "reset_idle";
    int          ack_count = 0;
    int          rec_count = 0;
    int          rx_bytes  = 0;
    logic        prev_busy = 1'b0;

    tdc_link_top #(
        .NUM_CHANNELS   (NUM_CH),
        .FIFO_ADDR_BITS (FIFO_BITS),
        .CLKS_PER_BIT   (CLKS_PER_BIT)
    ) tdc_link_top_i (
        .clk            (clk),
        .rst            (rst),
        .tdc_valid      (tdc_valid),
        .tdc_data       (tdc_data),
        .line_mark      (line_mark),
        .frame_mark     (frame_mark),
        .frame_reversed (frame_reversed),
        .tdc_ack        (tdc_ack),
        .line_ack       (line_ack),
        .frame_ack      (frame_ack),
        .tx             (tx),
        .tx_busy        (tx_busy)
    );

    always #10 clk = ~clk;

    task automatic stop_run();
        $display("tests failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_mismatch(input string test, input logic [47:0] exp,
                                   input logic [47:0] act);
        $display("[ERROR] %s: expected %h, actual %h", test, exp, act);
        stop_run();
    endtask

    task automatic report_failure(input string what);
        $display("Check failed in %s: %s", test_name, what);
        stop_run();
    endtask

    task automatic push_event(input int ch, input int kind, input logic [31:0] data);
        ev_ch.push_back(ch);
        ev_kind.push_back(kind);
        ev_data.push_back(data);
    endtask

    // Each source shows its oldest pending event
    task automatic apply_requests();
        logic [NUM_CH-1:0]       tv;
        logic [NUM_CH-1:0]       lm;
        logic [NUM_CH-1:0]       fm;
        logic [NUM_CH-1:0]       fr;
        logic [NUM_CH-1:0][31:0] td;
        tv = '0;
        lm = '0;
        fm = '0;
        fr = frame_reversed;
        td = tdc_data;
        for (int j = 0; j < ev_ch.size(); j++) begin
            if (ev_kind[j] == KIND_TDC && !tv[ev_ch[j]]) begin
                tv[ev_ch[j]] = 1'b1;
                td[ev_ch[j]] = ev_data[j];
            end else if (ev_kind[j] == KIND_LINE) begin
                lm[ev_ch[j]] = 1'b1;
            end else if (ev_kind[j] == KIND_FRAME && !fm[ev_ch[j]]) begin
                fm[ev_ch[j]] = 1'b1;
                fr[ev_ch[j]] = ev_data[j][0];
            end
        end
        tdc_valid      = tv;
        tdc_data       = td;
        line_mark      = lm;
        frame_mark     = fm;
        frame_reversed = fr;
    endtask

    // Model arbiter against the acknowledges of this cycle
    task automatic check_grant();
        logic [47:0] acks;
        logic [47:0] exp_acks;
        logic [31:0] payload;
        logic [15:0] code;
        int          exp_ch;
        int          exp_kind;
        int          idx;
        acks     = 48'({frame_ack, line_ack, tdc_ack});
        exp_ch   = -1;
        exp_kind = KIND_TDC;
        idx      = -1;
        for (int c = 0; c < NUM_CH; c++) begin
            if (exp_ch < 0) begin
                if (tdc_valid[c]) begin
                    exp_ch   = c;
                    exp_kind = KIND_TDC;
                end else if (line_mark[c]) begin
                    exp_ch   = c;
                    exp_kind = KIND_LINE;
                end else if (frame_mark[c]) begin
                    exp_ch   = c;
                    exp_kind = KIND_FRAME;
                end
            end
        end
        if (acks != '0) begin
            assert ($onehot(acks)) else report_failure("more than one acknowledge high");
            assert (exp_ch >= 0) else report_failure("acknowledge without a pending request");
            exp_acks = 48'(1) << (exp_kind * NUM_CH + exp_ch);
            assert (acks == exp_acks) else report_mismatch(test_name, exp_acks, acks);
            if (exp_kind == KIND_TDC) begin
                payload = tdc_data[exp_ch];
            end else if (exp_kind == KIND_LINE) begin
                payload = {16'h000D, 16'h000D};
            end else begin
                code    = frame_reversed[exp_ch] ? 16'h000E : 16'h000F;
                payload = {code, code};
            end
            expected_q.push_back({payload, 16'(exp_ch + 1)});
            for (int j = 0; j < ev_ch.size(); j++) begin
                if (idx < 0 && ev_ch[j] == exp_ch && ev_kind[j] == exp_kind) begin
                    idx = j;
                end
            end
            ev_ch.delete(idx);
            ev_kind.delete(idx);
            ev_data.delete(idx);
            ack_count++;
        end
    endtask

    task automatic check_cycle();
        if (rst) begin
            assert ({frame_ack, line_ack, tdc_ack} == '0)
                else report_mismatch(test_name, 48'(0), 48'({frame_ack, line_ack, tdc_ack}));
            assert (tx_busy == 1'b0) else report_mismatch(test_name, 48'(0), 48'(tx_busy));
        end else begin
            check_grant();
            if (prev_busy && !tx_busy) begin
                assert (rx_bytes > 0 && rx_bytes % 6 == 0)
                    else report_failure("busy dropped before the last stop bit");
            end
        end
        if (!tx_busy) begin
            assert (tx == 1'b1) else report_mismatch(test_name, 48'(1), 48'(tx));
        end
        prev_busy = tx_busy;
    endtask

    task automatic receive_byte(output logic [7:0] b);
        @(negedge tx);
        #(MID_NS);
        assert (tx == 1'b0) else report_failure("start bit not low at mid-bit");
        for (int k = 0; k < 8; k++) begin
            #(BIT_NS);
            b[k] = tx;
        end
        #(BIT_NS);
        assert (tx == 1'b1) else report_failure("stop bit not high");
        assert (tx_busy) else report_failure("busy low inside a record");
        rx_bytes++;
    endtask

    task automatic receive_record();
        logic [47:0] rec;
        logic [7:0]  b;
        for (int n = 0; n < 6; n++) begin
            receive_byte(b);
            rec[n*8 +: 8] = b;   // Channel number comes first
        end
        assert (expected_q.size() > 0) else report_failure("record received with none expected");
        assert (rec == expected_q[0]) else report_mismatch(test_name, expected_q[0], rec);
        void'(expected_q.pop_front());
        rec_count++;
    endtask

    task automatic wait_drained();
        @(negedge clk);
        while (ev_ch.size() != 0 || expected_q.size() != 0 || tx_busy) begin
            @(negedge clk);
        end
    endtask

    initial begin
        forever begin
            @(posedge clk);
            #1;
            apply_requests();
        end
    end

    initial begin
        forever begin
            @(negedge clk);
            check_cycle();
        end
    end

    initial begin
        @(negedge rst);
        forever receive_record();
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: run did not finish within %0d ns", WATCHDOG_NS);
        stop_run();
    end

    initial begin
        void'($urandom(37));
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (4) @(negedge clk);

        test_name = "measurement";
        for (int c = 0; c < NUM_CH; c++) begin
            push_event(c, KIND_TDC, $urandom());
            wait_drained();
        end

        test_name = "marker_codes";
        for (int c = 0; c < NUM_CH; c++) begin
            // Line, reversed frame, forward frame in turn
            push_event(c, (c % 3 == 0) ? KIND_LINE : KIND_FRAME, 32'((c % 3) == 1));
            wait_drained();
        end

        test_name = "priority";
        for (int c = NUM_CH - 1; c >= 0; c--) begin
            push_event(c, KIND_FRAME, $urandom());
            push_event(c, KIND_LINE, 32'd0);
            push_event(c, KIND_TDC, $urandom());
        end
        wait_drained();

        test_name = "backpressure";
        for (int n = 0; n < BURST_LEN; n++) begin
            push_event(int'($urandom_range(NUM_CH - 1, 0)), int'($urandom_range(2, 0)),
                       $urandom());
        end
        wait_drained();

        // Line must stay quiet for a whole record time
        repeat (60 * CLKS_PER_BIT) @(negedge clk);

        if (ack_count == TOTAL_RECORDS && rec_count == TOTAL_RECORDS
                && rx_bytes == 6 * TOTAL_RECORDS && !tx_busy) begin
            $display("all tests passed");
            $finish;
        end else begin
            $display("Line not idle after the last record: %0d records, %0d bytes received",
                     rec_count, rx_bytes);
            stop_run();
        end
    end

endmodule

// File: rtl/tdc_link_top.sv
`timescale 1ns/1ps

module tdc_link_top #(
    parameter int NUM_CHANNELS   = 6,
    parameter int FIFO_ADDR_BITS = 4,
    parameter int CLKS_PER_BIT   = 8
) (
    input  logic                                       clk,
    input  logic                                       rst,
    input  logic [NUM_CHANNELS-1:0]                    tdc_valid,
    input  tdc_link_pkg::payload_t [NUM_CHANNELS-1:0]  tdc_data,
    input  logic [NUM_CHANNELS-1:0]                    line_mark,
    input  logic [NUM_CHANNELS-1:0]                    frame_mark,
    input  logic [NUM_CHANNELS-1:0]                    frame_reversed,
    output logic [NUM_CHANNELS-1:0]                    tdc_ack,
    output logic [NUM_CHANNELS-1:0]                    line_ack,
    output logic [NUM_CHANNELS-1:0]                    frame_ack,
    output logic                                       tx,
    output logic                                       tx_busy
);

    logic                  rec_valid;
    logic                  rec_ready;
    tdc_link_pkg::record_t rec_data;
    logic                  fifo_valid;
    logic                  fifo_ready;
    tdc_link_pkg::record_t fifo_data;

    event_arbiter #(.NUM_CHANNELS(NUM_CHANNELS)) event_arbiter_i (
        .clk            (clk),
        .rst            (rst),
        .tdc_valid      (tdc_valid),
        .tdc_data       (tdc_data),
        .line_mark      (line_mark),
        .frame_mark     (frame_mark),
        .frame_reversed (frame_reversed),
        .tdc_ack        (tdc_ack),
        .line_ack       (line_ack),
        .frame_ack      (frame_ack),
        .rec_valid      (rec_valid),
        .rec_ready      (rec_ready),
        .rec_data       (rec_data)
    );

    record_fifo #(.ADDR_BITS(FIFO_ADDR_BITS)) record_fifo_i (
        .clk      (clk),
        .rst      (rst),
        .wr_valid (rec_valid),
        .wr_ready (rec_ready),
        .wr_data  (rec_data),
        .rd_valid (fifo_valid),
        .rd_ready (fifo_ready),
        .rd_data  (fifo_data)
    );

    uart_record_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) uart_record_tx_i (
        .clk       (clk),
        .rst       (rst),
        .rec_valid (fifo_valid),
        .rec_ready (fifo_ready),
        .rec_data  (fifo_data),
        .tx        (tx),
        .tx_busy   (tx_busy)
    );

endmodule

// File: rtl/uart_record_tx.sv
`timescale 1ns/1ps

module uart_record_tx #(
    parameter int CLKS_PER_BIT = 8
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  rec_valid,
    output logic                  rec_ready,
    input  tdc_link_pkg::record_t rec_data,
    output logic                  tx,
    output logic                  tx_busy
);

    localparam int CNT_W  = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
    localparam int BYTE_W = $clog2(tdc_link_pkg::BYTES_PER_RECORD);

    tdc_link_pkg::tx_state_t state;
    logic [CNT_W-1:0]        clk_cnt;
    logic [2:0]              bit_idx;
    logic [BYTE_W-1:0]       byte_idx;
    logic                    bit_end;
    logic                    last_byte;
    tdc_link_pkg::record_t   rec_latch;
    tdc_link_pkg::byte_t     cur_byte;
    tdc_link_pkg::byte_t     data_sr;

    assign rec_ready = (state == tdc_link_pkg::IDLE);
    assign bit_end   = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));
    assign last_byte = (byte_idx == BYTE_W'(tdc_link_pkg::BYTES_PER_RECORD - 1));

    // Least significant byte first, so the channel number leads
    assign cur_byte = rec_latch[byte_idx*8 +: 8];

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= tdc_link_pkg::IDLE;
            tx       <= 1'b1;
            tx_busy  <= 1'b0;
            clk_cnt  <= '0;
            bit_idx  <= '0;
            byte_idx <= '0;
        end else begin
            clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
            case (state)
                tdc_link_pkg::IDLE: begin
                    clk_cnt <= '0;
                    if (rec_valid) begin
                        state    <= tdc_link_pkg::START;
                        tx       <= 1'b0;   // First start bit
                        tx_busy  <= 1'b1;
                        byte_idx <= '0;
                    end
                end
                tdc_link_pkg::START: begin
                    if (bit_end) begin
                        state   <= tdc_link_pkg::DATA;
                        tx      <= cur_byte[0];
                        bit_idx <= '0;
                    end
                end
                tdc_link_pkg::DATA: begin
                    if (bit_end) begin
                        if (bit_idx == 3'd7) begin
                            state <= tdc_link_pkg::STOP;
                            tx    <= 1'b1;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                            tx      <= data_sr[0];
                        end
                    end
                end
                tdc_link_pkg::STOP: begin
                    if (bit_end) begin
                        if (last_byte) begin
                            state   <= tdc_link_pkg::IDLE;
                            tx_busy <= 1'b0;
                        end else begin
                            state    <= tdc_link_pkg::START;
                            tx       <= 1'b0;
                            byte_idx <= byte_idx + 1'b1;
                        end
                    end
                end
                default: begin
                    state <= tdc_link_pkg::IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rec_valid && rec_ready) begin
            rec_latch <= rec_data;
        end
        if (state == tdc_link_pkg::START && bit_end) begin
            data_sr <= cur_byte >> 1;   // Bit 0 already on the line
        end else if (state == tdc_link_pkg::DATA && bit_end) begin
            data_sr <= data_sr >> 1;
        end
    end

endmodule

// File: rtl/record_fifo.sv
`timescale 1ns/1ps

module record_fifo #(
    parameter int ADDR_BITS = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  wr_valid,
    output logic                  wr_ready,
    input  tdc_link_pkg::record_t wr_data,
    output logic                  rd_valid,
    input  logic                  rd_ready,
    output tdc_link_pkg::record_t rd_data
);

    localparam int DEPTH = 1 << ADDR_BITS;

    tdc_link_pkg::record_t mem [DEPTH];

    // Extra MSB tells full from empty
    logic [ADDR_BITS:0] wr_ptr;
    logic [ADDR_BITS:0] rd_ptr;
    logic               full;
    logic               empty;
    logic               do_write;
    logic               do_read;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[ADDR_BITS] != rd_ptr[ADDR_BITS])
                && (wr_ptr[ADDR_BITS-1:0] == rd_ptr[ADDR_BITS-1:0]);

    // A read in the same cycle frees the slot being written
    assign wr_ready = !full || rd_ready;
    assign rd_valid = !empty;
    assign rd_data  = mem[rd_ptr[ADDR_BITS-1:0]];   // Show-ahead head

    assign do_write = wr_valid && wr_ready;
    assign do_read  = rd_valid && rd_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr[ADDR_BITS-1:0]] <= wr_data;
        end
    end

endmodule

// File: rtl/event_arbiter.sv
`timescale 1ns/1ps

module event_arbiter #(
    parameter int NUM_CHANNELS = 6
) (
    input  logic                                       clk,
    input  logic                                       rst,
    input  logic [NUM_CHANNELS-1:0]                    tdc_valid,
    input  tdc_link_pkg::payload_t [NUM_CHANNELS-1:0]  tdc_data,
    input  logic [NUM_CHANNELS-1:0]                    line_mark,
    input  logic [NUM_CHANNELS-1:0]                    frame_mark,
    input  logic [NUM_CHANNELS-1:0]                    frame_reversed,
    output logic [NUM_CHANNELS-1:0]                    tdc_ack,
    output logic [NUM_CHANNELS-1:0]                    line_ack,
    output logic [NUM_CHANNELS-1:0]                    frame_ack,
    output logic                                       rec_valid,
    input  logic                                       rec_ready,
    output tdc_link_pkg::record_t                      rec_data
);

    logic                   out_valid;
    tdc_link_pkg::record_t  out_data;
    logic                   load_en;
    logic                   grant;
    tdc_link_pkg::payload_t next_payload;
    tdc_link_pkg::chan_id_t next_chan;

    // Output stage free, or emptied by the FIFO this cycle
    assign load_en = !out_valid || rec_ready;

    always_comb begin
        grant        = 1'b0;
        tdc_ack      = '0;
        line_ack     = '0;
        frame_ack    = '0;
        next_payload = '0;
        next_chan    = '0;
        // Lowest channel wins; measurement before line before frame
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            if (load_en && !grant) begin
                if (tdc_valid[i]) begin
                    grant        = 1'b1;
                    tdc_ack[i]   = 1'b1;
                    next_payload = tdc_data[i];
                    next_chan    = tdc_link_pkg::chan_id_t'(i + 1);
                end else if (line_mark[i]) begin
                    grant        = 1'b1;
                    line_ack[i]  = 1'b1;
                    next_payload = tdc_link_pkg::marker_payload(tdc_link_pkg::MARK_LINE);
                    next_chan    = tdc_link_pkg::chan_id_t'(i + 1);
                end else if (frame_mark[i]) begin
                    grant        = 1'b1;
                    frame_ack[i] = 1'b1;
                    next_payload = tdc_link_pkg::marker_payload(
                        tdc_link_pkg::frame_code(frame_reversed[i]));
                    next_chan    = tdc_link_pkg::chan_id_t'(i + 1);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (load_en) begin
            out_valid <= grant;   // Drops when accepted with nothing new
        end
    end

    always_ff @(posedge clk) begin
        if (load_en && grant) begin
            out_data <= tdc_link_pkg::make_record(next_payload, next_chan);
        end
    end

    assign rec_valid = out_valid;
    assign rec_data  = out_data;

endmodule

// File: rtl/tdc_link_pkg.sv
package tdc_link_pkg;

    // Field widths of the logged record
    typedef logic [31:0] payload_t;
    typedef logic [15:0] chan_id_t;
    typedef logic [47:0] record_t;   // {payload, channel}
    typedef logic [7:0]  byte_t;

    // Marker codes, doubled into the payload
    localparam logic [15:0] MARK_LINE      = 16'h000D;
    localparam logic [15:0] MARK_FRAME_REV = 16'h000E;
    localparam logic [15:0] MARK_FRAME_FWD = 16'h000F;

    localparam int BYTES_PER_RECORD = 6;

    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } tx_state_t;

    // Marker payload carries the code in both halves
    function automatic payload_t marker_payload(input logic [15:0] code);
        return {code, code};
    endfunction

    function automatic record_t make_record(input payload_t payload, input chan_id_t chan);
        return {payload, chan};
    endfunction

    // Marker code for a frame event
    function automatic logic [15:0] frame_code(input logic reversed);
        if (reversed) begin
            return MARK_FRAME_REV;
        end
        return MARK_FRAME_FWD;
    endfunction

endpackage
